// ==== common/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    // ------------------------------------------------------------
    // Data path width
    // ------------------------------------------------------------
    localparam int xlen = 32;

    // ------------------------------------------------------------
    // Memory instruction opcodes
    // ------------------------------------------------------------
    typedef logic [6:0] opcodeT;

    localparam opcodeT opLoad  = 7'b0000011;
    localparam opcodeT opStore = 7'b0100011;

    // Funct3 encodings shared by loads and stores
    localparam logic [2:0] fnB  = 3'b000;
    localparam logic [2:0] fnH  = 3'b001;
    localparam logic [2:0] fnW  = 3'b010;
    localparam logic [2:0] fnBu = 3'b100;
    localparam logic [2:0] fnHu = 3'b101;

    typedef enum logic [1:0] {
        widthByte,
        widthHalf,
        widthWord
    } accessWidthT;

    // Low two funct3 bits carry the size, bit 2 the unsigned flag
    function automatic accessWidthT widthOf(input logic [2:0] funct3);
        case (funct3)
            fnB, fnBu: return widthByte;
            fnH, fnHu: return widthHalf;
            fnW:       return widthWord;
            default:   return widthWord;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== common/memMapPkg.sv ====
`default_nettype none

package memMapPkg;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    // Bit 31 set selects the UART, all else is RAM
    localparam logic [31:0] ioBase = 32'h8000_0000;

    // Word index carried on the bus, byte address bits 31:2
    localparam int wordAddrBits = 30;

    // ------------------------------------------------------------
    // Data RAM
    // ------------------------------------------------------------
    localparam int ramWords     = 1024;
    localparam int ramIndexBits = $clog2(ramWords);

    // ------------------------------------------------------------
    // UART registers, word offsets
    // ------------------------------------------------------------
    localparam int uartOffsetBits = 2;

    localparam logic [uartOffsetBits-1:0] uartTxOffset     = 2'd0;
    localparam logic [uartOffsetBits-1:0] uartRxOffset     = 2'd1;
    localparam logic [uartOffsetBits-1:0] uartStatusOffset = 2'd2;

    // Status word bits
    localparam int rxValidBit = 0;

endpackage

`default_nettype wire

// ==== common/memBusIf.sv ====
`default_nettype none

interface memBusIf;
    import rvIsaPkg::*;
    import memMapPkg::*;

    // Word index, not byte address
    logic [wordAddrBits-1:0] addr;
    logic [xlen-1:0]         wdata;
    logic [xlen/8-1:0]       wstrb;
    logic                    we;
    logic                    re;
    logic [xlen-1:0]         rdata;

    modport host (
        output addr, wdata, wstrb, we, re,
        input  rdata
    );

    modport target (
        input  addr, wdata, wstrb, we, re,
        output rdata
    );

endinterface

`default_nettype wire

// ==== logic/storeAlign.sv ====
`default_nettype none

module storeAlign (
    input  wire logic [2:0]               funct3,
    input  wire logic [1:0]               offset,
    input  wire logic [rvIsaPkg::xlen-1:0] storeData,
    output logic      [rvIsaPkg::xlen-1:0] laneData,
    output logic      [3:0]               laneStrobe,
    output logic                          misalignedAccess
);
    import rvIsaPkg::*;

    accessWidthT width;

    assign width = widthOf(funct3);

    // ------------------------------------------------------------
    // Lane placement
    // ------------------------------------------------------------
    // Data is replicated across lanes, the strobe picks the live one
    always_comb
    begin
        laneData         = storeData;
        laneStrobe       = 4'b1111;
        misalignedAccess = 1'b0;
        case (width)
            widthByte:
            begin
                laneData   = {4{storeData[7:0]}};
                laneStrobe = 4'b0001 << offset;
            end
            widthHalf:
            begin
                laneData         = {2{storeData[15:0]}};
                laneStrobe       = 4'b0011 << offset;
                // Halfword must sit on an even byte
                misalignedAccess = offset[0];
            end
            widthWord:
            begin
                laneData         = storeData;
                laneStrobe       = 4'b1111;
                misalignedAccess = |offset;
            end
            default:
            begin
                laneData         = storeData;
                laneStrobe       = 4'b1111;
                misalignedAccess = |offset;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/loadAlign.sv ====
`default_nettype none

module loadAlign (
    input  wire logic [2:0]               funct3,
    input  wire logic [1:0]               offset,
    input  wire logic                     misalignedAccess,
    input  wire logic [rvIsaPkg::xlen-1:0] rdata,
    output logic      [rvIsaPkg::xlen-1:0] loadValue
);
    import rvIsaPkg::*;

    accessWidthT width;
    logic        signedLoad;
    logic [7:0]  laneByte;
    logic [15:0] laneHalf;

    assign width      = widthOf(funct3);
    // lbu and lhu have funct3 bit 2 set
    assign signedLoad = ~funct3[2];

    // ------------------------------------------------------------
    // Lane select
    // ------------------------------------------------------------
    always_comb
    begin
        case (offset)
            2'b00:   laneByte = rdata[7:0];
            2'b01:   laneByte = rdata[15:8];
            2'b10:   laneByte = rdata[23:16];
            2'b11:   laneByte = rdata[31:24];
            default: laneByte = rdata[7:0];
        endcase
    end

    // Odd offsets never reach here unflagged, so bit 1 is enough
    assign laneHalf = offset[1] ? rdata[31:16] : rdata[15:0];

    // ------------------------------------------------------------
    // Extension
    // ------------------------------------------------------------
    always_comb
    begin
        case (width)
            widthByte:
                loadValue = {{(xlen-8){signedLoad & laneByte[7]}}, laneByte};
            widthHalf:
                loadValue = {{(xlen-16){signedLoad & laneHalf[15]}}, laneHalf};
            widthWord:
                loadValue = rdata;
            default:
                loadValue = rdata;
        endcase
        // Flagged accesses return zero
        if (misalignedAccess)
        begin
            loadValue = '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dataMem.sv ====
`default_nettype none

module dataMem (
    input wire logic clk,
    memBusIf.target  bus
);
    import rvIsaPkg::*;
    import memMapPkg::*;

    logic [xlen-1:0]         mem [ramWords];
    logic [ramIndexBits-1:0] index;

    // Upper word address bits alias onto the RAM
    assign index = bus.addr[ramIndexBits-1:0];

    // ------------------------------------------------------------
    // Read port, combinational
    // ------------------------------------------------------------
    assign bus.rdata = bus.re ? mem[index] : '0;

    // ------------------------------------------------------------
    // Write port, byte strobed
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (bus.we)
        begin
            for (int lane = 0; lane < xlen/8; lane++)
            begin
                if (bus.wstrb[lane])
                begin
                    mem[index][8*lane +: 8] <= bus.wdata[8*lane +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== uart/uartRegs.sv ====
`default_nettype none

module uartRegs (
    input  wire logic       clk,
    input  wire logic       rstN,
    memBusIf.target         bus,
    output logic      [7:0] txByte,
    output logic            txStrobe,
    input  wire logic [7:0] rxByte,
    input  wire logic       rxStrobe
);
    import rvIsaPkg::*;
    import memMapPkg::*;

    logic [uartOffsetBits-1:0] regSel;
    logic                      txWrite;
    logic                      rxRead;
    logic [7:0]                rxData;
    logic                      rxValid;
    logic [xlen-1:0]           statusWord;

    assign regSel = bus.addr[uartOffsetBits-1:0];

    // Tx takes the low byte, so lane 0 must be strobed
    assign txWrite = bus.we && (regSel == uartTxOffset) && bus.wstrb[0];
    assign rxRead  = bus.re && (regSel == uartRxOffset);

    // ------------------------------------------------------------
    // Transmit side
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            txStrobe <= 1'b0;
        end
        else
        begin
            txStrobe <= txWrite;
        end
    end

    always_ff @(posedge clk)
    begin
        if (txWrite)
        begin
            txByte <= bus.wdata[7:0];
        end
    end

    // ------------------------------------------------------------
    // Receive side
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            rxData  <= 8'h00;
            rxValid <= 1'b0;
        end
        else
        begin
            // A fresh byte wins over a read in the same cycle
            if (rxStrobe)
            begin
                rxData  <= rxByte;
                rxValid <= 1'b1;
            end
            else if (rxRead)
            begin
                rxValid <= 1'b0;
            end
        end
    end

    always_comb
    begin
        statusWord             = '0;
        statusWord[rxValidBit] = rxValid;
    end

    // Read mux, tx and unmapped offsets read as zero
    always_comb
    begin
        bus.rdata = '0;
        if (bus.re)
        begin
            case (regSel)
                uartRxOffset:     bus.rdata = {{(xlen-8){1'b0}}, rxData};
                uartStatusOffset: bus.rdata = statusWord;
                default:          bus.rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/memAccessUnit.sv ====
`default_nettype none

module memAccessUnit (
    input  wire logic                      clk,
    input  wire logic                      rstN,
    input  wire logic                      valid,
    input  wire rvIsaPkg::opcodeT          opcode,
    input  wire logic [2:0]                funct3,
    input  wire logic [rvIsaPkg::xlen-1:0] address,
    input  wire logic [rvIsaPkg::xlen-1:0] storeData,
    output logic                           loadValid,
    output logic      [rvIsaPkg::xlen-1:0] loadData,
    output logic                           misaligned,
    output logic      [7:0]                txByte,
    output logic                           txStrobe,
    input  wire logic [7:0]                rxByte,
    input  wire logic                      rxStrobe
);
    import rvIsaPkg::*;
    import memMapPkg::*;

    logic [xlen-1:0]         laneData;
    logic [3:0]              laneStrobe;
    logic                    misalignedAccess;
    logic                    ioSel;
    logic                    isLoad;
    logic                    isStore;
    logic                    doLoad;
    logic                    doStore;
    logic [wordAddrBits-1:0] wordAddr;
    logic [xlen-1:0]         readWord;
    logic [xlen-1:0]         loadValue;

    memBusIf ramBus ();
    memBusIf ioBus ();

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------
    assign ioSel    = |(address & ioBase);
    assign isLoad   = valid && (opcode == opLoad);
    assign isStore  = valid && (opcode == opStore);
    assign doLoad   = isLoad && !misalignedAccess;
    assign doStore  = isStore && !misalignedAccess;
    assign wordAddr = address[xlen-1:2];

    storeAlign storeAlign_inst (
        .funct3           (funct3),
        .offset           (address[1:0]),
        .storeData        (storeData),
        .laneData         (laneData),
        .laneStrobe       (laneStrobe),
        .misalignedAccess (misalignedAccess)
    );

    // Both buses see the same request, only the enables differ
    assign ramBus.addr  = wordAddr;
    assign ramBus.wdata = laneData;
    assign ramBus.wstrb = laneStrobe;
    assign ramBus.we    = doStore && !ioSel;
    assign ramBus.re    = doLoad && !ioSel;

    assign ioBus.addr  = wordAddr;
    assign ioBus.wdata = laneData;
    assign ioBus.wstrb = laneStrobe;
    assign ioBus.we    = doStore && ioSel;
    assign ioBus.re    = doLoad && ioSel;

    dataMem dataMem_inst (
        .clk (clk),
        .bus (ramBus.target)
    );

    uartRegs uartRegs_inst (
        .clk      (clk),
        .rstN     (rstN),
        .bus      (ioBus.target),
        .txByte   (txByte),
        .txStrobe (txStrobe),
        .rxByte   (rxByte),
        .rxStrobe (rxStrobe)
    );

    // ------------------------------------------------------------
    // Load return path
    // ------------------------------------------------------------
    assign readWord = ioSel ? ioBus.rdata : ramBus.rdata;

    loadAlign loadAlign_inst (
        .funct3           (funct3),
        .offset           (address[1:0]),
        .misalignedAccess (misalignedAccess),
        .rdata            (readWord),
        .loadValue        (loadValue)
    );

    // One-cycle result stage
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            loadValid  <= 1'b0;
            loadData   <= '0;
            misaligned <= 1'b0;
        end
        else
        begin
            loadValid  <= isLoad;
            misaligned <= (isLoad || isStore) && misalignedAccess;
            if (isLoad)
            begin
                loadData <= loadValue;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/memAccessUnitTb.sv ====
`default_nettype none

module memAccessUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    import rvIsaPkg::*;
    import memMapPkg::*;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 10;
    localparam int windowWords = 64;
    localparam int nMerge      = 100;
    localparam int nExtend     = 100;
    localparam int nMisaligned = 40;
    localparam int nTx         = 10;
    localparam int nRx         = 10;
    localparam int numRequests = 2 * windowWords + 2 * nMerge + 2 * nExtend
                               + 2 * nMisaligned + nTx + 4 * nRx + 1;
    localparam int timeoutNs   = numRequests * clkPeriod * 4 + resetCycles * clkPeriod;

    logic              clk = 1'b0;
    logic              rstN;
    logic              valid;
    opcodeT            opcode;
    logic [2:0]        funct3;
    logic [xlen-1:0]   address;
    logic [xlen-1:0]   storeData;
    logic              loadValid;
    logic [xlen-1:0]   loadData;
    logic              misaligned;
    logic [7:0]        txByte;
    logic              txStrobe;
    logic [7:0]        rxByte;
    logic              rxStrobe;

    integer seed       = 71;
    int     errorCount = 0;

    // Reference model of the RAM window bytes and rx state
    logic [7:0] modelMem [windowWords * 4];
    logic       modelRxValid;
    logic [7:0] modelRxData;

    memAccessUnit memAccessUnit_inst (
        .clk       (clk),
        .rstN      (rstN),
        .valid     (valid),
        .opcode    (opcode),
        .funct3    (funct3),
        .address   (address),
        .storeData (storeData),
        .loadValid (loadValid),
        .loadData  (loadData),
        .misaligned(misaligned),
        .txByte    (txByte),
        .txStrobe  (txStrobe),
        .rxByte    (rxByte),
        .rxStrobe  (rxStrobe)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // ------------------------------------------------------------
    // Model helpers
    // ------------------------------------------------------------
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("Fail %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    function automatic logic misalignedFor(input logic [2:0] f3, input logic [1:0] off);
        case (f3)
            fnH, fnHu: return off[0];
            fnW:       return off != 2'b00;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] uartAddr(input logic [1:0] regOffset);
        return ioBase | {28'h0, regOffset, 2'b00};
    endfunction

    function automatic logic [31:0] modelRead(input logic [31:0] addr);
        int base;
        base = {addr[7:2], 2'b00};
        if (addr[31])
        begin
            case (addr[3:2])
                uartRxOffset:     return {24'h0, modelRxData};
                uartStatusOffset: return {31'h0, modelRxValid};
                default:          return 32'h0;
            endcase
        end
        return {modelMem[base + 3], modelMem[base + 2], modelMem[base + 1], modelMem[base]};
    endfunction

    // Shift the addressed lane down, then extend by funct3
    function automatic logic [31:0] extractLoad(input logic [2:0] f3, input logic [1:0] off,
                                                input logic [31:0] word);
        logic [31:0] shifted;
        shifted = word >> (8 * off);
        case (f3)
            fnB:     return {{24{shifted[7]}}, shifted[7:0]};
            fnBu:    return {24'h0, shifted[7:0]};
            fnH:     return {{16{shifted[15]}}, shifted[15:0]};
            fnHu:    return {16'h0, shifted[15:0]};
            default: return word;
        endcase
    endfunction

    task automatic storeToModel(input logic [2:0] f3, input logic [31:0] addr,
                                input logic [31:0] data, output logic txExpected);
        int base;
        base       = addr[7:0];
        txExpected = 1'b0;
        if (addr[31])
        begin
            // Tx register only takes lane 0
            txExpected = (addr[3:2] == uartTxOffset) && (addr[1:0] == 2'b00);
        end
        else
        begin
            modelMem[base] = data[7:0];
            if (f3 != fnB)
            begin
                modelMem[base + 1] = data[15:8];
            end
            if (f3 == fnW)
            begin
                modelMem[base + 2] = data[23:16];
                modelMem[base + 3] = data[31:24];
            end
        end
    endtask

    // ------------------------------------------------------------
    // Request driver and checker
    // ------------------------------------------------------------
    task automatic doRequest(input opcodeT op, input logic [2:0] f3,
                             input logic [31:0] addr, input logic [31:0] data);
        logic        isLoad;
        logic        expMis;
        logic        expTx;
        logic [31:0] expData;
        isLoad  = (op == opLoad);
        expMis  = misalignedFor(f3, addr[1:0]);
        expTx   = 1'b0;
        expData = 32'h0;
        if (isLoad && !expMis)
        begin
            expData = extractLoad(f3, addr[1:0], modelRead(addr));
            // Reading rx data consumes the byte
            if (addr[31] && addr[3:2] == uartRxOffset)
            begin
                modelRxValid = 1'b0;
            end
        end
        else if (!isLoad && !expMis)
        begin
            storeToModel(f3, addr, data, expTx);
        end
        valid     = 1'b1;
        opcode    = op;
        funct3    = f3;
        address   = addr;
        storeData = data;
        @(negedge clk);
        valid = 1'b0;
        checkValue("loadValid", isLoad, loadValid);
        checkValue("misaligned", expMis, misaligned);
        if (isLoad)
        begin
            checkValue("loadData", expData, loadData);
        end
        checkValue("txStrobe", expTx, txStrobe);
        if (expTx)
        begin
            checkValue("txByte", data[7:0], txByte);
        end
    endtask

    task automatic receiveByte(input logic [7:0] b);
        rxByte   = b;
        rxStrobe = 1'b1;
        @(negedge clk);
        rxStrobe     = 1'b0;
        modelRxValid = 1'b1;
        modelRxData  = b;
        checkValue("loadValid", 0, loadValid);
        checkValue("txStrobe", 0, txStrobe);
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial
    begin
        logic [5:0]  idx;
        logic [1:0]  off;
        logic [2:0]  f3;
        logic [31:0] data;
        logic [31:0] r;
        rstN         = 1'b0;
        valid        = 1'b0;
        opcode       = opLoad;
        funct3       = fnW;
        address      = 32'h0;
        storeData    = 32'h0;
        rxByte       = 8'h00;
        rxStrobe     = 1'b0;
        modelRxValid = 1'b0;
        modelRxData  = 8'h00;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkValue("loadValid", 0, loadValid);
        checkValue("misaligned", 0, misaligned);
        checkValue("txStrobe", 0, txStrobe);
        checkValue("loadData", 0, loadData);

        // Fill the window with words, then read them back
        for (int i = 0; i < windowWords; i++)
        begin
            doRequest(opStore, fnW, i * 4, $random(seed));
        end
        for (int i = 0; i < windowWords; i++)
        begin
            doRequest(opLoad, fnW, i * 4, 32'h0);
        end

        // Partial stores merged into existing words
        for (int i = 0; i < nMerge; i++)
        begin
            idx  = $random(seed);
            data = $random(seed);
            r    = $random(seed);
            off  = $random(seed);
            f3   = r[0] ? fnB : fnH;
            if (f3 == fnH)
            begin
                off[0] = 1'b0;
            end
            doRequest(opStore, f3, {24'h0, idx, off}, data);
            doRequest(opLoad, fnW, {24'h0, idx, 2'b00}, 32'h0);
        end

        // Sign and zero extension with sign bits forced both ways
        for (int i = 0; i < nExtend; i++)
        begin
            idx  = $random(seed);
            data = $random(seed);
            if (i % 2)
                data = data | 32'h8080_8080;
            else
                data = data & 32'h7f7f_7f7f;
            doRequest(opStore, fnW, {24'h0, idx, 2'b00}, data);
            r   = $random(seed);
            off = $random(seed);
            case (r % 5)
                0:       f3 = fnB;
                1:       f3 = fnBu;
                2:       f3 = fnH;
                3:       f3 = fnHu;
                default: f3 = fnW;
            endcase
            if (f3 == fnH || f3 == fnHu)
                off[0] = 1'b0;
            else if (f3 == fnW)
                off = 2'b00;
            doRequest(opLoad, f3, {24'h0, idx, off}, 32'h0);
        end

        // Misaligned halves and words with an aligned check after each
        for (int i = 0; i < nMisaligned; i++)
        begin
            idx  = $random(seed);
            data = $random(seed);
            r    = $random(seed);
            f3   = r[0] ? fnW : (r[1] ? fnHu : fnH);
            if (f3 == fnW)
            begin
                off = r[4:3];
                if (off == 2'b00)
                    off = 2'b11;
            end
            else
            begin
                off = {r[2], 1'b1};
            end
            if (r[5])
                doRequest(opStore, (f3 == fnHu) ? fnH : f3, {24'h0, idx, off}, data);
            else
                doRequest(opLoad, f3, {24'h0, idx, off}, 32'h0);
            doRequest(opLoad, fnW, {24'h0, idx, 2'b00}, 32'h0);
        end

        // UART transmit
        for (int i = 0; i < nTx; i++)
        begin
            doRequest(opStore, fnW, uartAddr(uartTxOffset), $random(seed));
        end

        // UART receive, status, data, status again
        for (int i = 0; i < nRx; i++)
        begin
            data = $random(seed);
            receiveByte(data[7:0]);
            doRequest(opLoad, fnW, uartAddr(uartStatusOffset), 32'h0);
            doRequest(opLoad, fnW, uartAddr(uartRxOffset), 32'h0);
            doRequest(opLoad, fnW, uartAddr(uartStatusOffset), 32'h0);
        end

        $display("Checks finished with %0d errors", errorCount);
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(timeoutNs);
        $display("Timeout: the run did not finish within %0d ns", timeoutNs);
        $display("Checks finished with %0d errors", errorCount);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== memAccessUnit.f ====
common/rvIsaPkg.sv
common/memMapPkg.sv
common/memBusIf.sv
logic/storeAlign.sv
logic/loadAlign.sv
logic/dataMem.sv
uart/uartRegs.sv
logic/memAccessUnit.sv
verification/memAccessUnitTb.sv
